/* verilog/mfifo_pkg.sv */
// Shared sizes and the staging slot type for the multi-FIFO; import it wherever these are needed
package mfifo_pkg;

  // Four logical FIFOs carved out of one shared RAM
  localparam int NUM_FIFOS = 4;

  // Total number of words in the shared data RAM
  localparam int DEPTH = 16;

  // Width of one data word
  localparam int WIDTH = 8;

  // Width of the binary FIFO ID on the push port
  localparam int ID_W = 2;

  // Width of a RAM address
  localparam int ADDR_W = 4;

  // Width of an item count, which must reach DEPTH itself
  localparam int COUNT_W = 5;

  // One staging slot per FIFO sits between the RAM and the pop port
  // A pending slot has a read in flight, and its data lands on the next edge
  typedef enum logic [1:0] {
    slot_empty   = 2'd0,
    slot_pending = 2'd1,
    slot_full    = 2'd2
  } slot_state_t;

endpackage

/* verilog/mfifo_size_calc.sv */
// Checks the base/bound layout of the logical FIFOs and derives each FIFO's size from it
`timescale 1ns/1ps

module mfifo_size_calc (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::ADDR_W-1:0]  config_base,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::ADDR_W-1:0]  config_bound,
  output logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::COUNT_W-1:0] config_size,
  output logic                                             config_error
);

  import mfifo_pkg::*;

  // One violation flag per FIFO, OR-ed together before the register
  logic [NUM_FIFOS-1:0] fifo_bad;

  // Bounds are inclusive, so a range of one address still holds one item
  always_comb begin
    for (int i = 0; i < NUM_FIFOS; i++) begin
      config_size[i] = COUNT_W'(config_bound[i]) - COUNT_W'(config_base[i]) + COUNT_W'(1);
    end
  end

  // A FIFO is bad if it reaches past the RAM, is turned inside out,
  // or starts at or below where the previous FIFO ends
  always_comb begin
    for (int i = 0; i < NUM_FIFOS; i++) begin
      fifo_bad[i] = (COUNT_W'(config_base[i]) >= COUNT_W'(DEPTH)) ||
                    (COUNT_W'(config_bound[i]) >= COUNT_W'(DEPTH)) ||
                    (config_base[i] > config_bound[i]);
      if (i > 0) begin
        if (config_base[i] <= config_bound[i-1]) begin
          fifo_bad[i] = 1'b1;
        end
      end
    end
  end

  // Held low in reset, then tracks the layout from the first edge after it
  always_ff @(posedge clk) begin
    if (rst) begin
      config_error <= 1'b0;
    end else begin
      config_error <= |fifo_bad;
    end
  end

endmodule

/* verilog/mfifo_push_ctrl.sv */
// Push side of the multi-FIFO; turns an accepted push into one RAM write at the addressed tail
`timescale 1ns/1ps

module mfifo_push_ctrl (
  input  logic                                            clk,
  input  logic                                            rst,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::ADDR_W-1:0] config_base,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::ADDR_W-1:0] config_bound,
  input  logic                                            config_error,
  input  logic                                            push_valid,
  input  logic [mfifo_pkg::WIDTH-1:0]                     push_data,
  input  logic [mfifo_pkg::ID_W-1:0]                      push_fifo_id,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0]                 push_full,
  output logic                                            push_ready,
  output logic                                            ram_wr_valid,
  output logic [mfifo_pkg::ADDR_W-1:0]                    ram_wr_addr,
  output logic [mfifo_pkg::WIDTH-1:0]                     ram_wr_data,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::ADDR_W-1:0] tail,
  output logic [mfifo_pkg::NUM_FIFOS-1:0]                 advance_tail,
  output logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::ADDR_W-1:0] tail_next
);

  import mfifo_pkg::*;

  // Set on the first edge out of reset, the same edge that first loads config_error,
  // so a bad layout never gets a window in which a push could slip through
  logic push_en;

  always_ff @(posedge clk) begin
    if (rst) begin
      push_en <= 1'b0;
    end else begin
      push_en <= 1'b1;
    end
  end

  // Only the addressed FIFO's fullness matters; other IDs keep flowing
  assign push_ready = push_en && !config_error && !push_full[push_fifo_id];

  // Every accepted push is exactly one RAM write
  assign ram_wr_valid = push_valid && push_ready;
  assign ram_wr_addr  = tail[push_fifo_id];
  assign ram_wr_data  = push_data;

  // Decode the ID into a one-hot tail advance
  always_comb begin
    for (int i = 0; i < NUM_FIFOS; i++) begin
      advance_tail[i] = ram_wr_valid && (push_fifo_id == ID_W'(i));
    end
  end

  // Next tail for every FIFO, wrapping from bound back to base
  always_comb begin
    for (int i = 0; i < NUM_FIFOS; i++) begin
      if (tail[i] == config_bound[i]) begin
        tail_next[i] = config_base[i];
      end else begin
        tail_next[i] = tail[i] + ADDR_W'(1);
      end
    end
  end

endmodule

/* verilog/mfifo_ptr_mgr.sv */
// Keeps the tail, head and item count of each logical FIFO and flags full and empty from them
`timescale 1ns/1ps

module mfifo_ptr_mgr (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::ADDR_W-1:0]  config_base,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::ADDR_W-1:0]  config_bound,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::COUNT_W-1:0] config_size,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0]                  advance_tail,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::ADDR_W-1:0]  tail_next,
  output logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::ADDR_W-1:0]  tail,
  output logic [mfifo_pkg::NUM_FIFOS-1:0]                  push_full,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0]                  head_ready,
  output logic [mfifo_pkg::NUM_FIFOS-1:0]                  head_valid,
  output logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::ADDR_W-1:0]  head,
  output logic [mfifo_pkg::NUM_FIFOS-1:0]                  ram_empty
);

  import mfifo_pkg::*;

  // Items currently held in the RAM for each FIFO
  logic [NUM_FIFOS-1:0][COUNT_W-1:0] count;
  logic [NUM_FIFOS-1:0][ADDR_W-1:0]  head_next;

  // Head wraps the same way the push side wraps the tail
  always_comb begin
    for (int i = 0; i < NUM_FIFOS; i++) begin
      if (head[i] == config_bound[i]) begin
        head_next[i] = config_base[i];
      end else begin
        head_next[i] = head[i] + ADDR_W'(1);
      end
    end
  end

  // The layout is stable across reset, so both pointers start at base
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_FIFOS; i++) begin
      if (rst) begin
        tail[i] <= config_base[i];
        head[i] <= config_base[i];
      end else begin
        if (advance_tail[i]) begin
          tail[i] <= tail_next[i];
        end
        if (head_ready[i]) begin
          head[i] <= head_next[i];
        end
      end
    end
  end

  // A head advance frees the entry when the read is issued, not when it pops,
  // so a push and an advance in the same cycle leave the count unchanged
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_FIFOS; i++) begin
      if (rst) begin
        count[i] <= '0;
      end else begin
        case ({advance_tail[i], head_ready[i]})
          2'b10:   count[i] <= count[i] + COUNT_W'(1);
          2'b01:   count[i] <= count[i] - COUNT_W'(1);
          default: count[i] <= count[i];
        endcase
      end
    end
  end

  // Flags come straight from the count
  always_comb begin
    for (int i = 0; i < NUM_FIFOS; i++) begin
      push_full[i]  = (count[i] == config_size[i]);
      ram_empty[i]  = (count[i] == '0);
      head_valid[i] = !ram_empty[i];
    end
  end

endmodule

/* verilog/mfifo_data_ram.sv */
// Shared data storage for all logical FIFOs; one write port and one registered read port
`timescale 1ns/1ps

module mfifo_data_ram (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         wr_valid,
  input  logic [mfifo_pkg::ADDR_W-1:0] wr_addr,
  input  logic [mfifo_pkg::WIDTH-1:0]  wr_data,
  input  logic                         rd_addr_valid,
  input  logic [mfifo_pkg::ADDR_W-1:0] rd_addr,
  output logic                         rd_data_valid,
  output logic [mfifo_pkg::WIDTH-1:0]  rd_data
);

  import mfifo_pkg::*;

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read data shows up one cycle after the address
  always_ff @(posedge clk) begin
    if (rd_addr_valid) begin
      rd_data <= mem[rd_addr];
    end
  end

  // The valid flag trails the address by the same one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_data_valid <= 1'b0;
    end else begin
      rd_data_valid <= rd_addr_valid;
    end
  end

endmodule

/* verilog/mfifo_pop_ctrl.sv */
// Pop side of the multi-FIFO; refills each staging slot from the RAM by round-robin and drives the pop ports
`timescale 1ns/1ps

module mfifo_pop_ctrl (
  input  logic                                            clk,
  input  logic                                            rst,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0]                 head_valid,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::ADDR_W-1:0] head,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0]                 ram_empty,
  output logic [mfifo_pkg::NUM_FIFOS-1:0]                 head_ready,
  output logic                                            ram_rd_addr_valid,
  output logic [mfifo_pkg::ADDR_W-1:0]                    ram_rd_addr,
  input  logic                                            ram_rd_data_valid,
  input  logic [mfifo_pkg::WIDTH-1:0]                     ram_rd_data,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0]                 pop_ready,
  output logic [mfifo_pkg::NUM_FIFOS-1:0]                 pop_valid,
  output logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::WIDTH-1:0]  pop_data,
  output logic [mfifo_pkg::NUM_FIFOS-1:0]                 pop_empty
);

  import mfifo_pkg::*;

  slot_state_t                     slot_state [NUM_FIFOS];
  logic [NUM_FIFOS-1:0][WIDTH-1:0] slot_data;

  // Last FIFO that won the read port, and the FIFO whose read is in flight
  logic [ID_W-1:0] rr_ptr;
  logic [ID_W-1:0] rd_id;

  logic [NUM_FIFOS-1:0] req;
  logic [NUM_FIFOS-1:0] grant;
  logic [ID_W-1:0]      grant_id;
  logic                 grant_any;

  // A slot asks for a refill when it is empty, or when it is full and
  // drains this very cycle, which lets a FIFO keep one item per two cycles
  always_comb begin
    for (int i = 0; i < NUM_FIFOS; i++) begin
      req[i] = head_valid[i] &&
               ((slot_state[i] == slot_empty) ||
                ((slot_state[i] == slot_full) && pop_ready[i]));
    end
  end

  // Search starts just after the previous winner and goes once around
  always_comb begin
    int cand;
    grant     = '0;
    grant_id  = '0;
    grant_any = 1'b0;
    for (int k = 1; k <= NUM_FIFOS; k++) begin
      cand = (int'(rr_ptr) + k) % NUM_FIFOS;
      if (!grant_any && req[cand]) begin
        grant_any = 1'b1;
        grant_id  = ID_W'(cand);
      end
    end
    if (grant_any) begin
      grant[grant_id] = 1'b1;
    end
  end

  // The grant is the read itself; the pointer manager frees the entry now
  assign head_ready        = grant;
  assign ram_rd_addr_valid = grant_any;
  assign ram_rd_addr       = head[grant_id];

  // Start with FIFO 0 first in line
  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr <= ID_W'(NUM_FIFOS - 1);
      rd_id  <= '0;
    end else if (grant_any) begin
      rr_ptr <= grant_id;
      rd_id  <= grant_id;
    end
  end

  // A granted slot can never be the one that receives data this cycle,
  // since receiving needs a pending slot and a grant needs empty or full
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_FIFOS; i++) begin
      if (rst) begin
        slot_state[i] <= slot_empty;
      end else if (grant[i]) begin
        slot_state[i] <= slot_pending;
      end else if (ram_rd_data_valid && (rd_id == ID_W'(i))) begin
        slot_state[i] <= slot_full;
      end else if (pop_valid[i] && pop_ready[i]) begin
        slot_state[i] <= slot_empty;
      end
    end
  end

  // Data word of each slot follows the returned read
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_FIFOS; i++) begin
      if (ram_rd_data_valid && (rd_id == ID_W'(i))) begin
        slot_data[i] <= ram_rd_data;
      end
    end
  end

  // Pop outputs come straight off the slots
  always_comb begin
    for (int i = 0; i < NUM_FIFOS; i++) begin
      pop_valid[i] = (slot_state[i] == slot_full);
      pop_empty[i] = ram_empty[i] && (slot_state[i] == slot_empty);
    end
  end

  assign pop_data = slot_data;

endmodule

/* verilog/mfifo_top.sv */
// Top level of the shared-storage multi-FIFO; connects config check, push, pointers, RAM and pop
`timescale 1ns/1ps

module mfifo_top (
  input  logic                                            clk,
  input  logic                                            rst,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::ADDR_W-1:0] config_base,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::ADDR_W-1:0] config_bound,
  output logic                                            config_error,
  input  logic                                            push_valid,
  output logic                                            push_ready,
  input  logic [mfifo_pkg::WIDTH-1:0]                     push_data,
  input  logic [mfifo_pkg::ID_W-1:0]                      push_fifo_id,
  output logic [mfifo_pkg::NUM_FIFOS-1:0]                 push_full,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0]                 pop_ready,
  output logic [mfifo_pkg::NUM_FIFOS-1:0]                 pop_valid,
  output logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::WIDTH-1:0]  pop_data,
  output logic [mfifo_pkg::NUM_FIFOS-1:0]                 pop_empty
);

  import mfifo_pkg::*;

  logic [NUM_FIFOS-1:0][COUNT_W-1:0] config_size;

  // Write path from the push side
  logic                             ram_wr_valid;
  logic [ADDR_W-1:0]                ram_wr_addr;
  logic [WIDTH-1:0]                 ram_wr_data;
  logic [NUM_FIFOS-1:0]             advance_tail;
  logic [NUM_FIFOS-1:0][ADDR_W-1:0] tail_next;
  logic [NUM_FIFOS-1:0][ADDR_W-1:0] tail;

  // Head path between pointers and pop side
  logic [NUM_FIFOS-1:0]             head_ready;
  logic [NUM_FIFOS-1:0]             head_valid;
  logic [NUM_FIFOS-1:0][ADDR_W-1:0] head;
  logic [NUM_FIFOS-1:0]             ram_empty;

  // Read path through the RAM
  logic              ram_rd_addr_valid;
  logic [ADDR_W-1:0] ram_rd_addr;
  logic              ram_rd_data_valid;
  logic [WIDTH-1:0]  ram_rd_data;

  mfifo_size_calc u_size_calc (
    .clk(clk), .rst(rst), .config_base(config_base), .config_bound(config_bound),
    .config_size(config_size), .config_error(config_error)
  );

  mfifo_push_ctrl u_push_ctrl (
    .clk(clk), .rst(rst), .config_base(config_base), .config_bound(config_bound),
    .config_error(config_error), .push_valid(push_valid), .push_data(push_data),
    .push_fifo_id(push_fifo_id), .push_full(push_full), .push_ready(push_ready),
    .ram_wr_valid(ram_wr_valid), .ram_wr_addr(ram_wr_addr), .ram_wr_data(ram_wr_data),
    .tail(tail), .advance_tail(advance_tail), .tail_next(tail_next)
  );

  mfifo_ptr_mgr u_ptr_mgr (
    .clk(clk), .rst(rst), .config_base(config_base), .config_bound(config_bound),
    .config_size(config_size), .advance_tail(advance_tail), .tail_next(tail_next),
    .tail(tail), .push_full(push_full), .head_ready(head_ready),
    .head_valid(head_valid), .head(head), .ram_empty(ram_empty)
  );

  mfifo_data_ram u_data_ram (
    .clk(clk), .rst(rst), .wr_valid(ram_wr_valid), .wr_addr(ram_wr_addr),
    .wr_data(ram_wr_data), .rd_addr_valid(ram_rd_addr_valid), .rd_addr(ram_rd_addr),
    .rd_data_valid(ram_rd_data_valid), .rd_data(ram_rd_data)
  );

  mfifo_pop_ctrl u_pop_ctrl (
    .clk(clk), .rst(rst), .head_valid(head_valid), .head(head), .ram_empty(ram_empty),
    .head_ready(head_ready), .ram_rd_addr_valid(ram_rd_addr_valid),
    .ram_rd_addr(ram_rd_addr), .ram_rd_data_valid(ram_rd_data_valid),
    .ram_rd_data(ram_rd_data), .pop_ready(pop_ready), .pop_valid(pop_valid),
    .pop_data(pop_data), .pop_empty(pop_empty)
  );

endmodule

/* sim/mfifo_props.sv */
// Concurrent assertions on the multi-FIFO internals; attached to mfifo_top by the bind below
`timescale 1ns/1ps

module mfifo_props (
  input logic                                                  clk,
  input logic                                                  rst,
  input logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::ADDR_W-1:0] config_base,
  input logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::ADDR_W-1:0] config_bound,
  input logic                                                  config_error,
  input logic                                                  ram_wr_valid,
  input logic [mfifo_pkg::ADDR_W-1:0]                          ram_rd_addr,
  input logic [mfifo_pkg::NUM_FIFOS-1:0]                       head_ready,
  input logic [mfifo_pkg::NUM_FIFOS-1:0]                       pop_valid,
  input logic [mfifo_pkg::NUM_FIFOS-1:0]                       pop_empty
);

  import mfifo_pkg::*;

  // Failed assertions, read back by the testbench for its summary
  int fail_count = 0;

  // The read port serves one FIFO per cycle, and a FIFO that just won
  // has its read in flight, so it cannot win again on the next cycle
  one_read: assert property (@(posedge clk) disable iff (rst)
    $onehot0(head_ready) && ((head_ready & $past(head_ready)) == '0))
    else begin
      $error("more than one RAM read, or a FIFO read on two cycles in a row");
      fail_count++;
    end

  no_write_on_bad_layout: assert property (@(posedge clk) disable iff (rst)
    config_error |-> !ram_wr_valid)
    else begin
      $error("RAM written while the layout is flagged bad");
      fail_count++;
    end

  // A FIFO's reads stay inside its own address range
  for (genvar i = 0; i < NUM_FIFOS; i++) begin : g_range
    rd_in_range: assert property (@(posedge clk) disable iff (rst)
      head_ready[i] |-> (ram_rd_addr >= config_base[i]) && (ram_rd_addr <= config_bound[i]))
      else begin
        $error("RAM read for FIFO %0d outside its range", i);
        fail_count++;
      end
  end

  valid_not_empty: assert property (@(posedge clk) disable iff (rst)
    (pop_valid & pop_empty) == '0)
    else begin
      $error("pop_valid and pop_empty high together");
      fail_count++;
    end

endmodule

bind mfifo_top mfifo_props u_props (
  .clk(clk), .rst(rst), .config_base(config_base), .config_bound(config_bound),
  .config_error(config_error), .ram_wr_valid(ram_wr_valid),
  .ram_rd_addr(ram_rd_addr),
  .head_ready(head_ready), .pop_valid(pop_valid), .pop_empty(pop_empty)
);

/* sim/mfifo_checker.sv */
// Reference model for the multi-FIFO; mirrors every accepted push and compares pops and flags
`timescale 1ns/1ps

module mfifo_checker (
  input  logic                                                   clk,
  input  logic                                                   rst,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::ADDR_W-1:0] config_base,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::ADDR_W-1:0] config_bound,
  input  logic                                                   config_error,
  input  logic                                                   push_valid,
  input  logic                                                   push_ready,
  input  logic [mfifo_pkg::WIDTH-1:0]                            push_data,
  input  logic [mfifo_pkg::ID_W-1:0]                             push_fifo_id,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0]                        push_full,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0]                        pop_ready,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0]                        pop_valid,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0][mfifo_pkg::WIDTH-1:0]  pop_data,
  input  logic [mfifo_pkg::NUM_FIFOS-1:0]                        pop_empty,
  output int                                                     error_count,
  output int                                                     push_count,
  output int                                                     pop_count
);

  import mfifo_pkg::*;

  // One ring buffer per FIFO, far deeper than any legal FIFO can get
  logic [WIDTH-1:0] q_data  [NUM_FIFOS][32];
  int               q_cycle [NUM_FIFOS][32];
  int               q_rd    [NUM_FIFOS];
  int               q_len   [NUM_FIFOS];
  // Cycles a FIFO has held items without showing pop_valid
  int               wait_cnt [NUM_FIFOS];
  int               cycle = 0;
  logic             live = 1'b0;
  logic             in_reset = 1'b0;

  initial begin
    error_count = 0;
    push_count  = 0;
    pop_count   = 0;
  end

  // Ranges must sit inside the RAM, run upward, and follow each other in order
  function automatic logic layout_bad(input logic [NUM_FIFOS-1:0][ADDR_W-1:0] base,
                                      input logic [NUM_FIFOS-1:0][ADDR_W-1:0] bound);
    logic bad;
    bad = 1'b0;
    for (int i = 0; i < NUM_FIFOS; i++) begin
      if (int'(base[i]) >= DEPTH || int'(bound[i]) >= DEPTH || base[i] > bound[i]) begin
        bad = 1'b1;
      end
      if (i > 0) begin
        if (!(base[i] > bound[i-1])) begin
          bad = 1'b1;
        end
      end
    end
    return bad;
  endfunction

  // RAM range plus the one staging slot in front of the pop port
  function automatic int fifo_cap(input int i);
    return int'(config_bound[i]) - int'(config_base[i]) + 2;
  endfunction

  task automatic log_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    error_count++;
    $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, exp, act);
  endtask

  task automatic count_failure(input string what);
    error_count++;
    $display("error at %0t: %s", $time, what);
  endtask

  // Samples at the rising edge, before the DUT registers move
  always @(posedge clk) begin
    logic bad_cfg;
    int   cap;
    int   slot;
    int   id;
    if (rst) begin
      if (in_reset && config_error !== 1'b0) begin
        log_mismatch("config_error", 32'd0, 32'(config_error));
      end
      in_reset = 1'b1;
      live = 1'b0;
      for (int i = 0; i < NUM_FIFOS; i++) begin
        q_rd[i] = 0;
        q_len[i] = 0;
        wait_cnt[i] = 0;
      end
    end else begin
      in_reset = 1'b0;
      cycle++;
      bad_cfg = layout_bad(config_base, config_bound);
      // The flag and the push gate settle one edge after reset
      if (live) begin
        if (config_error !== bad_cfg) begin
          log_mismatch("config_error", 32'(bad_cfg), 32'(config_error));
        end
        id = int'(push_fifo_id);
        cap = fifo_cap(id);
        // One item short of capacity the answer hangs on whether the slot
        // has been refilled yet, so only the clear cases are checked
        if (bad_cfg || q_len[id] >= cap) begin
          if (push_ready !== 1'b0) begin
            log_mismatch("push_ready", 32'd0, 32'(push_ready));
          end
        end else if (q_len[id] < cap - 1) begin
          if (push_ready !== 1'b1) begin
            log_mismatch("push_ready", 32'd1, 32'(push_ready));
          end
        end
      end
      for (int i = 0; i < NUM_FIFOS; i++) begin
        cap = fifo_cap(i);
        if (pop_empty[i] !== (q_len[i] == 0)) begin
          log_mismatch($sformatf("pop_empty[%0d]", i), 32'(q_len[i] == 0), 32'(pop_empty[i]));
        end
        if (live && !bad_cfg) begin
          if (q_len[i] == cap && push_full[i] !== 1'b1) begin
            log_mismatch($sformatf("push_full[%0d]", i), 32'd1, 32'(push_full[i]));
          end
          if (push_full[i] === 1'b1 && q_len[i] < cap - 1) begin
            count_failure($sformatf("FIFO %0d full with only %0d items", i, q_len[i]));
          end
        end
        if (pop_valid[i] && pop_ready[i]) begin
          pop_count++;
          if (q_len[i] == 0) begin
            count_failure($sformatf("FIFO %0d popped with nothing pushed", i));
          end else begin
            slot = q_rd[i];
            if (pop_data[i] !== q_data[i][slot]) begin
              log_mismatch($sformatf("pop_data[%0d]", i), 32'(q_data[i][slot]),
                           32'(pop_data[i]));
            end
            // pop_valid rises two cycles after the push at the earliest,
            // and the handshake lands on the edge after that
            if (cycle - q_cycle[i][slot] < 3) begin
              count_failure($sformatf("FIFO %0d popped an item too soon after its push", i));
            end
            q_rd[i] = (slot + 1) % 32;
            q_len[i]--;
          end
        end
        // Round-robin fairness bounds how long a loaded FIFO can show nothing
        if (q_len[i] > 0 && !pop_valid[i]) begin
          wait_cnt[i]++;
        end else begin
          wait_cnt[i] = 0;
        end
        if (wait_cnt[i] == 2 * NUM_FIFOS + 3) begin
          count_failure($sformatf("FIFO %0d held items without pop_valid too long", i));
        end
      end
      if (push_valid && push_ready) begin
        push_count++;
        id = int'(push_fifo_id);
        if (bad_cfg) begin
          count_failure("push accepted while the layout is bad");
        end else if (q_len[id] >= fifo_cap(id)) begin
          count_failure($sformatf("push accepted beyond the capacity of FIFO %0d", id));
        end else begin
          slot = (q_rd[id] + q_len[id]) % 32;
          q_data[id][slot] = push_data;
          q_cycle[id][slot] = cycle;
          q_len[id]++;
        end
      end
      live = 1'b1;
    end
  end

endmodule

/* sim/mfifo_tb.sv */
// Testbench for the multi-FIFO; seeded random pushes and pops over good and bad layouts
`timescale 1ns/1ps

module mfifo_tb;

  import mfifo_pkg::*;

  logic                             clk;
  logic                             rst;
  logic [NUM_FIFOS-1:0][ADDR_W-1:0] config_base;
  logic [NUM_FIFOS-1:0][ADDR_W-1:0] config_bound;
  logic                             push_valid;
  logic [WIDTH-1:0]                 push_data;
  logic [ID_W-1:0]                  push_fifo_id;
  logic [NUM_FIFOS-1:0]             pop_ready;
  logic                             config_error;
  logic                             push_ready;
  logic [NUM_FIFOS-1:0]             push_full;
  logic [NUM_FIFOS-1:0]             pop_valid;
  logic [NUM_FIFOS-1:0][WIDTH-1:0]  pop_data;
  logic [NUM_FIFOS-1:0]             pop_empty;
  int                               error_count;
  int                               push_count;
  int                               pop_count;
  int                               timeouts = 0;
  int                               wait_limit = 200;
  // Handshake seen at the last rising edge, read back on the falling edge
  logic                             accepted = 1'b0;

  mfifo_top u_dut (
    .clk(clk), .rst(rst), .config_base(config_base), .config_bound(config_bound),
    .config_error(config_error), .push_valid(push_valid), .push_ready(push_ready),
    .push_data(push_data), .push_fifo_id(push_fifo_id), .push_full(push_full),
    .pop_ready(pop_ready), .pop_valid(pop_valid), .pop_data(pop_data), .pop_empty(pop_empty)
  );

  mfifo_checker u_checker (
    .clk(clk), .rst(rst), .config_base(config_base), .config_bound(config_bound),
    .config_error(config_error), .push_valid(push_valid), .push_ready(push_ready),
    .push_data(push_data), .push_fifo_id(push_fifo_id), .push_full(push_full),
    .pop_ready(pop_ready), .pop_valid(pop_valid), .pop_data(pop_data), .pop_empty(pop_empty),
    .error_count(error_count), .push_count(push_count), .pop_count(pop_count)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    accepted <= push_valid && push_ready;
  end

  // The layout only changes while reset is held
  task automatic restart(input logic [NUM_FIFOS-1:0][ADDR_W-1:0] bases,
                         input logic [NUM_FIFOS-1:0][ADDR_W-1:0] bounds);
    @(negedge clk);
    rst = 1'b1;
    push_valid = 1'b0;
    pop_ready = '0;
    config_base = bases;
    config_bound = bounds;
    repeat (16) @(negedge clk);
    rst = 1'b0;
  endtask

  // A refused push is held unchanged until it goes through
  task automatic random_cycle(input int push_pct, input int pop_pct);
    @(negedge clk);
    if (!push_valid || accepted) begin
      push_valid = ($urandom % 100) < push_pct;
      push_fifo_id = ID_W'($urandom);
      push_data = WIDTH'($urandom);
    end
    for (int i = 0; i < NUM_FIFOS; i++) begin
      pop_ready[i] = ($urandom % 100) < pop_pct;
    end
  endtask

  task automatic push_item(input int id);
    int waited;
    @(negedge clk);
    push_valid = 1'b1;
    push_fifo_id = ID_W'(id);
    push_data = WIDTH'($urandom);
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!accepted && waited < wait_limit);
    if (!accepted) begin
      timeouts++;
      $display("timeout at %0t: push to FIFO %0d never accepted", $time, id);
    end
    push_valid = 1'b0;
  endtask

  // Finishes any held push, then waits until every FIFO reads empty
  task automatic drain();
    int waited;
    pop_ready = '1;
    waited = 0;
    while ((push_valid || !(&pop_empty)) && waited < wait_limit) begin
      @(negedge clk);
      if (accepted) begin
        push_valid = 1'b0;
      end
      waited++;
    end
    if (push_valid || !(&pop_empty)) begin
      timeouts++;
      $display("timeout at %0t: FIFOs did not drain", $time);
    end
  endtask

  // Fill one FIFO past its capacity while its pop port is stalled
  task automatic fill_fifo(input int id);
    int cap;
    cap = int'(config_bound[id]) - int'(config_base[id]) + 2;
    @(negedge clk);
    pop_ready = '1;
    pop_ready[id] = 1'b0;
    for (int k = 0; k < cap; k++) begin
      push_item(id);
    end
    // Another ID still gets through
    push_item((id + 1) % NUM_FIFOS);
    @(negedge clk);
    push_valid = 1'b1;
    push_fifo_id = ID_W'(id);
    push_data = WIDTH'($urandom);
    repeat (6) @(negedge clk);
    drain();
  endtask

  initial begin
    void'($urandom(32'hd5b1_1387));
    clk = 1'b0;
    rst = 1'b1;
    push_valid = 1'b0;
    push_data = '0;
    push_fifo_id = '0;
    pop_ready = '0;
    config_base = {4'd11, 4'd8, 4'd6, 4'd0};
    config_bound = {4'd15, 4'd10, 4'd7, 4'd5};

    // Good layout: random traffic, a drain, then a capacity fill of each FIFO
    restart({4'd11, 4'd8, 4'd6, 4'd0}, {4'd15, 4'd10, 4'd7, 4'd5});
    repeat (3000) random_cycle(60, 70);
    drain();
    for (int f = 0; f < NUM_FIFOS; f++) begin
      fill_fifo(f);
    end

    // Bad layouts: a range turned inside out, an overlap, and a descending order
    restart({4'd11, 4'd8, 4'd7, 4'd0}, {4'd15, 4'd10, 4'd6, 4'd5});
    repeat (200) random_cycle(80, 50);
    restart({4'd11, 4'd8, 4'd5, 4'd0}, {4'd15, 4'd10, 4'd7, 4'd5});
    repeat (200) random_cycle(80, 50);
    restart({4'd0, 4'd6, 4'd8, 4'd11}, {4'd5, 4'd7, 4'd10, 4'd15});
    repeat (200) random_cycle(80, 50);

    @(negedge clk);
    push_valid = 1'b0;
    $display("summary: %0d checker errors, %0d assertion failures, %0d timeouts, %0d pushes, %0d pops",
             error_count, u_dut.u_props.fail_count, timeouts, push_count, pop_count);
    if (error_count == 0 && u_dut.u_props.fail_count == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* files.f */
verilog/mfifo_pkg.sv
verilog/mfifo_size_calc.sv
verilog/mfifo_push_ctrl.sv
verilog/mfifo_ptr_mgr.sv
verilog/mfifo_data_ram.sv
verilog/mfifo_pop_ctrl.sv
verilog/mfifo_top.sv
sim/mfifo_props.sv
sim/mfifo_checker.sv
sim/mfifo_tb.sv
